/* verilog.f */
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_operand_latch.sv
design/ex_block.sv
design/ex_stage_top.sv
test/ex_stage_tb.sv

/* Makefile */
TOP := ex_stage_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/ex_stage_tb.sv */
// Self-checking testbench for the execute stage with reference model, stimulus and watchdog
`default_nettype none
`timescale 1ns/1ps

module ex_stage_tb;

  import ex_pkg::*;

  localparam int RADIX_LOG2 = 2;
  localparam int MULT_STEPS = XLEN / RADIX_LOG2;
  localparam int CLK_PERIOD = 40;
  // Operations per test
  localparam int IDLE_OPS   = 10;
  localparam int ARITH_OPS  = 70;
  localparam int SHIFT_OPS  = 96;
  localparam int BR_RANDOM  = 4;
  localparam int BRANCH_OPS = 6 * (BR_RANDOM + 5);
  localparam int MULT_RAND  = 16;
  localparam int MULT_OPS   = 9 + MULT_RAND;
  localparam int MIX_OPS    = 60;
  localparam int TEST_OPS   = IDLE_OPS + ARITH_OPS + SHIFT_OPS + BRANCH_OPS + MULT_OPS + MIX_OPS;
  // Twenty cycles per operation covers a full multiply with slack
  localparam int WATCHDOG_NS = (TEST_OPS * 20 + 500) * CLK_PERIOD;

  // One expected result, queued at issue
  typedef struct packed {
    alu_op_e         op;
    logic            mult;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] adder;
    logic            branch;
    int              due;
  } exp_t;

  logic            clk;
  logic            rst_n_i;
  logic            issue_i;
  alu_op_e         alu_operator_i;
  logic            mult_en_i;
  logic [XLEN-1:0] alu_operand_a_i;
  logic [XLEN-1:0] alu_operand_b_i;
  logic [4:0]      shifter_amt_i;
  logic [XLEN-1:0] regfile_wdata_o;
  logic [XLEN-1:0] alu_adder_result_o;
  logic [XLEN-1:0] jump_target_o;
  logic            branch_decision_o;
  logic            ex_ready_o;
  logic            ex_valid_o;

  // Scoreboard state
  exp_t  exp_q[$];
  int    cycle = 0;
  int    ready_lo = 1;
  int    ready_hi = 0;
  logic  checking = 1'b0;
  int    err_cnt = 0;
  int    chk_cnt = 0;
  int    op_cnt = 0;
  int    test_cnt = 0;
  int    test_err_base = 0;
  int    test_op_base = 0;
  string test_name = "reset";

  ex_stage_top #(
    .RADIX_LOG2 ( RADIX_LOG2 )
  ) uut (
    .clk                ( clk                ),
    .rst_n_i            ( rst_n_i            ),
    .issue_i            ( issue_i            ),
    .alu_operator_i     ( alu_operator_i     ),
    .mult_en_i          ( mult_en_i          ),
    .alu_operand_a_i    ( alu_operand_a_i    ),
    .alu_operand_b_i    ( alu_operand_b_i    ),
    .shifter_amt_i      ( shifter_amt_i      ),
    .regfile_wdata_o    ( regfile_wdata_o    ),
    .alu_adder_result_o ( alu_adder_result_o ),
    .jump_target_o      ( jump_target_o      ),
    .branch_decision_o  ( branch_decision_o  ),
    .ex_ready_o         ( ex_ready_o         ),
    .ex_valid_o         ( ex_valid_o         )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic void ref_exec(
    input  alu_op_e         op,
    input  logic            mult,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [4:0]      amt,
    output logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] adder,
    output logic            branch
  );
    logic sub;
    // Adder subtracts for SUB and every compare
    sub = op inside {ALU_SUB, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
                     ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    adder  = sub ? a - b : a + b;
    branch = 1'b0;
    wdata  = '0;
    case (op)
      ALU_ADD, ALU_SUB: wdata = adder;
      ALU_XOR:          wdata = a ^ b;
      ALU_OR:           wdata = a | b;
      ALU_AND:          wdata = a & b;
      ALU_SLL:          wdata = a << amt;
      ALU_SRL:          wdata = a >> amt;
      ALU_SRA:          wdata = $signed(a) >>> amt;
      ALU_SLT:          branch = $signed(a) < $signed(b);
      ALU_SLTU:         branch = a < b;
      ALU_EQ:           branch = (a == b);
      ALU_NE:           branch = (a != b);
      ALU_LT:           branch = $signed(a) < $signed(b);
      ALU_GE:           branch = $signed(a) >= $signed(b);
      ALU_LTU:          branch = a < b;
      ALU_GEU:          branch = a >= b;
      default:          wdata = '0;
    endcase
    // Set-less-than writes the comparison back
    if (op == ALU_SLT || op == ALU_SLTU) begin
      wdata = {{(XLEN-1){1'b0}}, branch};
    end
    // Multiply keeps the low word only
    if (mult) begin
      wdata = a * b;
    end
  endfunction

  function automatic string op_label(input alu_op_e op, input logic mult);
    if (mult) begin
      return "MUL";
    end
    return op.name();
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
    chk_cnt++;
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Drives one operation, back to back unless a multiply stalls the stage
  task automatic issue_op(input alu_op_e op, input logic mult, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic [4:0] amt);
    exp_t            e;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] adder;
    logic            branch;
    ref_exec(op, mult, a, b, amt, wdata, adder, branch);
    e.op     = op;
    e.mult   = mult;
    e.wdata  = wdata;
    e.adder  = adder;
    e.branch = branch;
    @(posedge clk);
    issue_i         <= 1'b1;
    alu_operator_i  <= op;
    mult_en_i       <= mult;
    alu_operand_a_i <= a;
    alu_operand_b_i <= b;
    shifter_amt_i   <= amt;
    // Sampled at the next edge, valid in the cycle after that
    e.due = cycle + 2 + (mult ? MULT_STEPS : 0);
    exp_q.push_back(e);
    op_cnt++;
    if (mult) begin
      // Stall window ends just before the done cycle
      ready_lo = cycle + 2;
      ready_hi = cycle + 1 + MULT_STEPS;
      @(posedge clk);
      issue_i <= 1'b0;
      // Next issue lands in the done cycle
      repeat (MULT_STEPS - 1) @(posedge clk);
    end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = err_cnt;
    test_op_base  = op_cnt;
  endtask

  // Drains outstanding results and reports the test
  task automatic finish_test();
    @(posedge clk);
    issue_i <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("test %-8s finished: %0d operations, %0d errors", test_name,
             op_cnt - test_op_base, err_cnt - test_err_base);
    test_cnt++;
  endtask

  ////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    exp_t e;
    logic ready_exp;
    cycle = cycle + 1;
    if (checking) begin
      ready_exp = !((cycle >= ready_lo) && (cycle <= ready_hi));
      if (ex_ready_o !== ready_exp) begin
        $display("Error: ex_ready_o is %b in cycle %0d but should be %b",
                 ex_ready_o, cycle, ready_exp);
        err_cnt++;
      end
      if (ex_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Error: ex_valid_o high in cycle %0d with no operation outstanding", cycle);
          err_cnt++;
        end else begin
          e = exp_q.pop_front();
          if (cycle != e.due) begin
            $display("Error: %s result arrived in cycle %0d instead of cycle %0d",
                     op_label(e.op, e.mult), cycle, e.due);
            err_cnt++;
          end
          check_value({test_name, " ", op_label(e.op, e.mult), " wdata"},
                      e.wdata, regfile_wdata_o);
          if (!e.mult) begin
            check_value({test_name, " ", op_label(e.op, e.mult), " adder"},
                        e.adder, alu_adder_result_o);
            check_value({test_name, " ", op_label(e.op, e.mult), " jump target"},
                        e.adder, jump_target_o);
            check_value({test_name, " ", op_label(e.op, e.mult), " branch"},
                        {{(XLEN-1){1'b0}}, e.branch}, {{(XLEN-1){1'b0}}, branch_decision_o});
          end
        end
      end else if (ex_valid_o !== 1'b0) begin
        $display("Error: ex_valid_o is unknown in cycle %0d", cycle);
        err_cnt++;
      end
      // A result that never showed up
      if (exp_q.size() != 0 && exp_q[0].due < cycle) begin
        e = exp_q.pop_front();
        $display("Error: no ex_valid_o for %s due in cycle %0d", op_label(e.op, e.mult), e.due);
        err_cnt++;
      end
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Error: watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    alu_op_e         arith_ops[$]  = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
                                       ALU_SLT, ALU_SLTU};
    alu_op_e         shift_ops[$]  = '{ALU_SLL, ALU_SRL, ALU_SRA};
    alu_op_e         branch_ops[$] = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    alu_op_e         all_ops[$]    = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
                                       ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
                                       ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    // Sign-boundary pairs
    logic [XLEN-1:0] bound_a[$]    = '{32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff,
                                       32'hffff_ffff};
    logic [XLEN-1:0] bound_b[$]    = '{32'h0000_0001, 32'h8000_0000, 32'h8000_0000,
                                       32'h0000_0000};
    logic [XLEN-1:0] corner[$]     = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff};
    logic [XLEN-1:0] x;
    int              sel;

    void'($urandom(32'h35bb_1daa));
    clk             = 1'b0;
    rst_n_i         = 1'b0;
    issue_i         = 1'b0;
    alu_operator_i  = ALU_ADD;
    mult_en_i       = 1'b0;
    alu_operand_a_i = '0;
    alu_operand_b_i = '0;
    shifter_amt_i   = '0;

    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;
    checking = 1'b1;

    // Idle after reset
    start_test("reset");
    @(negedge clk);
    check_value("reset ready", 32'd1, {{(XLEN-1){1'b0}}, ex_ready_o});
    check_value("reset valid", 32'd0, {{(XLEN-1){1'b0}}, ex_valid_o});
    repeat (IDLE_OPS) @(posedge clk);
    finish_test();

    start_test("arith");
    for (int i = 0; i < ARITH_OPS; i++) begin
      sel = $urandom_range(0, arith_ops.size() - 1);
      issue_op(arith_ops[sel], 1'b0, $urandom, $urandom, 5'($urandom_range(0, 31)));
    end
    finish_test();

    // Operand b is random and must not reach the shifter
    start_test("shift");
    for (int k = 0; k < shift_ops.size(); k++) begin
      for (int amt = 0; amt < 32; amt++) begin
        issue_op(shift_ops[k], 1'b0, $urandom, $urandom, 5'(amt));
      end
    end
    finish_test();

    start_test("branch");
    for (int k = 0; k < branch_ops.size(); k++) begin
      for (int r = 0; r < BR_RANDOM; r++) begin
        issue_op(branch_ops[k], 1'b0, $urandom, $urandom, 5'd0);
      end
      x = $urandom;
      issue_op(branch_ops[k], 1'b0, x, x, 5'd0);
      for (int p = 0; p < bound_a.size(); p++) begin
        issue_op(branch_ops[k], 1'b0, bound_a[p], bound_b[p], 5'd0);
      end
    end
    finish_test();

    start_test("mult");
    for (int i = 0; i < corner.size(); i++) begin
      for (int j = 0; j < corner.size(); j++) begin
        issue_op(ALU_ADD, 1'b1, corner[i], corner[j], 5'd0);
      end
    end
    for (int i = 0; i < MULT_RAND; i++) begin
      issue_op(ALU_ADD, 1'b1, $urandom, $urandom, 5'd0);
    end
    finish_test();

    // Roughly one multiply in four
    start_test("mixed");
    for (int i = 0; i < MIX_OPS; i++) begin
      sel = $urandom_range(0, all_ops.size() - 1);
      issue_op(all_ops[sel], ($urandom_range(0, 3) == 0), $urandom, $urandom,
               5'($urandom_range(0, 31)));
    end
    finish_test();

    $display("tests %0d, operations %0d, checks %0d, errors %0d",
             test_cnt, op_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/ex_stage_top.sv */
// Execute stage top joining the ID/EX operand latch and the execute block
`default_nettype none
`timescale 1ns/1ps

module ex_stage_top #(
  // Multiplier bits per step, 1, 2 or 4
  parameter int unsigned RADIX_LOG2 = 2
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // Issue from decode
  input  logic                    issue_i,
  input  ex_pkg::alu_op_e         alu_operator_i,
  input  logic                    mult_en_i,
  input  logic [ex_pkg::XLEN-1:0] alu_operand_a_i,
  input  logic [ex_pkg::XLEN-1:0] alu_operand_b_i,
  input  logic [4:0]              shifter_amt_i,
  // Results
  output logic [ex_pkg::XLEN-1:0] regfile_wdata_o,
  output logic [ex_pkg::XLEN-1:0] alu_adder_result_o,
  output logic [ex_pkg::XLEN-1:0] jump_target_o,
  output logic                    branch_decision_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  import ex_pkg::*;

  // ID/EX register toward execute
  alu_op_e         ex_operator;
  logic            ex_mult_en;
  logic [XLEN-1:0] ex_operand_a;
  logic [XLEN-1:0] ex_operand_b;
  logic [4:0]      ex_shifter_amt;
  logic            ex_op_valid;
  logic            ex_mult_start;
  logic            ex_mult_busy;

  ex_operand_latch operand_latch_i (
    .clk             ( clk             ),
    .rst_n_i         ( rst_n_i         ),
    .issue_i         ( issue_i         ),
    .alu_operator_i  ( alu_operator_i  ),
    .mult_en_i       ( mult_en_i       ),
    .alu_operand_a_i ( alu_operand_a_i ),
    .alu_operand_b_i ( alu_operand_b_i ),
    .shifter_amt_i   ( shifter_amt_i   ),
    .mult_busy_i     ( ex_mult_busy    ),
    .operator_o      ( ex_operator     ),
    .mult_en_o       ( ex_mult_en      ),
    .operand_a_o     ( ex_operand_a    ),
    .operand_b_o     ( ex_operand_b    ),
    .shifter_amt_o   ( ex_shifter_amt  ),
    .op_valid_o      ( ex_op_valid     ),
    .mult_start_o    ( ex_mult_start   ),
    .ex_ready_o      ( ex_ready_o      )
  );

  ex_block #(
    .RADIX_LOG2 ( RADIX_LOG2 )
  ) ex_block_i (
    .clk                   ( clk                ),
    .rst_n_i               ( rst_n_i            ),
    .alu_operator_i        ( ex_operator        ),
    .mult_en_i             ( ex_mult_en         ),
    .alu_operand_a_i       ( ex_operand_a       ),
    .alu_operand_b_i       ( ex_operand_b       ),
    .shifter_amt_i         ( ex_shifter_amt     ),
    .op_valid_i            ( ex_op_valid        ),
    .mult_start_i          ( ex_mult_start      ),
    .alu_adder_result_ex_o ( alu_adder_result_o ),
    .regfile_wdata_ex_o    ( regfile_wdata_o    ),
    .jump_target_o         ( jump_target_o      ),
    .branch_decision_o     ( branch_decision_o  ),
    .mult_busy_o           ( ex_mult_busy       ),
    .ex_valid_o            ( ex_valid_o         )
  );

endmodule

`default_nettype wire

/* design/ex_block.sv */
// Execute block hosting ALU and multiplier, selecting write-back data and valid
`default_nettype none
`timescale 1ns/1ps

module ex_block #(
  parameter int unsigned RADIX_LOG2 = 2
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // Held operation from the ID/EX register
  input  ex_pkg::alu_op_e         alu_operator_i,
  input  logic                    mult_en_i,
  input  logic [ex_pkg::XLEN-1:0] alu_operand_a_i,
  input  logic [ex_pkg::XLEN-1:0] alu_operand_b_i,
  input  logic [4:0]              shifter_amt_i,
  input  logic                    op_valid_i,
  input  logic                    mult_start_i,
  // Results
  output logic [ex_pkg::XLEN-1:0] alu_adder_result_ex_o,
  output logic [ex_pkg::XLEN-1:0] regfile_wdata_ex_o,
  // Jump and branch toward fetch
  output logic [ex_pkg::XLEN-1:0] jump_target_o,
  output logic                    branch_decision_o,
  output logic                    mult_busy_o,
  output logic                    ex_valid_o
);

  import ex_pkg::*;

  localparam int unsigned MULT_STEPS = XLEN / RADIX_LOG2;

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mult_result;
  logic            alu_cmp_result;
  logic            mult_done;

  // Write-back source follows the held multiply flag
  assign regfile_wdata_ex_o = mult_en_i ? mult_result : alu_result;

  // Branch handling
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_adder_result_ex_o;

  // ALU results valid in the capture cycle, products on done
  assign ex_valid_o = mult_en_i ? mult_done : op_valid_i;

  ////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .clk                 ( clk                   ),
    .operator_i          ( alu_operator_i        ),
    .operand_a_i         ( alu_operand_a_i       ),
    .operand_b_i         ( alu_operand_b_i       ),
    .shifter_amt_i       ( shifter_amt_i         ),
    .adder_result_o      ( alu_adder_result_ex_o ),
    .result_o            ( alu_result            ),
    .comparison_result_o ( alu_cmp_result        )
  );

  ex_mult #(
    .RADIX_LOG2 ( RADIX_LOG2 )
  ) mult_i (
    .clk      ( clk             ),
    .rst_n_i  ( rst_n_i         ),
    .start_i  ( mult_start_i    ),
    .op_a_i   ( alu_operand_a_i ),
    .op_b_i   ( alu_operand_b_i ),
    .busy_o   ( mult_busy_o     ),
    .done_o   ( mult_done       ),
    .result_o ( mult_result     )
  );

  // Every started multiply reports valid after exactly its step count
  a_mult_latency : assert property (@(posedge clk) disable iff (!rst_n_i)
    mult_start_i |-> ##MULT_STEPS ex_valid_o);

endmodule

`default_nettype wire

/* design/ex_operand_latch.sv */
// ID/EX register that captures an issued operation and stalls the issuer during a multiply
`default_nettype none
`timescale 1ns/1ps

module ex_operand_latch (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // Operation from decode
  input  logic                    issue_i,
  input  ex_pkg::alu_op_e         alu_operator_i,
  input  logic                    mult_en_i,
  input  logic [ex_pkg::XLEN-1:0] alu_operand_a_i,
  input  logic [ex_pkg::XLEN-1:0] alu_operand_b_i,
  input  logic [4:0]              shifter_amt_i,
  // Multiplier state from the execute block
  input  logic                    mult_busy_i,
  // Held operation toward the execute block
  output ex_pkg::alu_op_e         operator_o,
  output logic                    mult_en_o,
  output logic [ex_pkg::XLEN-1:0] operand_a_o,
  output logic [ex_pkg::XLEN-1:0] operand_b_o,
  output logic [4:0]              shifter_amt_o,
  output logic                    op_valid_o,
  output logic                    mult_start_o,
  output logic                    ex_ready_o
);

  import ex_pkg::*;

  alu_op_e         operator_q;
  logic [XLEN-1:0] operand_a_q;
  logic [XLEN-1:0] operand_b_q;
  logic [4:0]      shifter_amt_q;
  logic            mult_en_q;
  logic            op_valid_q;
  logic            accept;

  // Issue counts only while ready
  assign accept = issue_i & ex_ready_o;

  // Control bits
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_valid_q <= 1'b0;
      mult_en_q  <= 1'b0;
    end else begin
      op_valid_q <= accept;
      if (accept) begin
        mult_en_q <= mult_en_i;
      end
    end
  end

  // Operation payload, held until the next issue
  always_ff @(posedge clk) begin
    if (accept) begin
      operator_q    <= alu_operator_i;
      operand_a_q   <= alu_operand_a_i;
      operand_b_q   <= alu_operand_b_i;
      shifter_amt_q <= shifter_amt_i;
    end
  end

  assign operator_o    = operator_q;
  assign mult_en_o     = mult_en_q;
  assign operand_a_o   = operand_a_q;
  assign operand_b_o   = operand_b_q;
  assign shifter_amt_o = shifter_amt_q;
  assign op_valid_o    = op_valid_q;

  // Start pulse in the capture cycle of a multiply
  assign mult_start_o = op_valid_q & mult_en_q;

  // Start covers the gap before the multiplier reports busy
  assign ex_ready_o = ~(mult_start_o | mult_busy_i);

  // Decode must hold issue while the stage stalls
  a_issue_when_ready : assert property (@(posedge clk) disable iff (!rst_n_i)
    issue_i |-> ex_ready_o);

endmodule

`default_nettype wire

/* design/ex_mult.sv */
// Iterative shift-and-add multiplier returning the low word of the product
`default_nettype none
`timescale 1ns/1ps

module ex_mult #(
  // Operand b bits retired per step
  parameter int unsigned RADIX_LOG2 = 2
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  logic [ex_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_pkg::XLEN-1:0] op_b_i,
  output logic                    busy_o,
  output logic                    done_o,
  output logic [ex_pkg::XLEN-1:0] result_o
);

  import ex_pkg::*;

  localparam int unsigned STEPS = XLEN / RADIX_LOG2;
  localparam int unsigned CNT_W = $clog2(STEPS + 1);

  // Radix must lie in range and divide the word
  if (RADIX_LOG2 < MULT_RADIX_LOG2_MIN || RADIX_LOG2 > MULT_RADIX_LOG2_MAX ||
      (XLEN % RADIX_LOG2) != 0) begin : g_radix_check
    $error("ex_mult: RADIX_LOG2 must be 1, 2 or 4");
  end

  logic             active_q;
  logic [CNT_W-1:0] count_q;
  logic [XLEN-1:0]  mcand_q;
  logic [XLEN-1:0]  mplier_q;
  logic [XLEN-1:0]  acc_q;
  logic [XLEN-1:0]  partial;
  logic [XLEN-1:0]  acc_next;
  logic             last_step;

  // Multiplicand times the low radix digit of the multiplier
  always_comb begin
    partial = '0;
    for (int unsigned i = 0; i < RADIX_LOG2; i++) begin
      if (mplier_q[i]) begin
        partial = partial + (mcand_q << i);
      end
    end
  end

  assign acc_next = acc_q + partial;

  // Final digit is added combinationally so done lands one cycle early
  assign last_step = active_q && (count_q == CNT_W'(1));

  ////////////////////////////////////////////////////////////
  // Step control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      count_q  <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      count_q  <= CNT_W'(STEPS);
    end else if (active_q) begin
      active_q <= ~last_step;
      count_q  <= count_q - CNT_W'(1);
    end
  end

  // Operand shift registers and accumulator
  always_ff @(posedge clk) begin
    if (start_i) begin
      mcand_q  <= op_a_i;
      mplier_q <= op_b_i;
      acc_q    <= '0;
    end else if (active_q) begin
      mcand_q  <= mcand_q << RADIX_LOG2;
      mplier_q <= mplier_q >> RADIX_LOG2;
      acc_q    <= acc_next;
    end
  end

  assign done_o   = last_step;
  // Busy clears in the done cycle so the issuer sees ready there
  assign busy_o   = active_q & ~last_step;
  assign result_o = acc_next;

  // A new start only once the previous product is out
  a_no_start_when_busy : assert property (@(posedge clk) disable iff (!rst_n_i)
    start_i |-> !busy_o);

  // Done ends the operation, no restart in the done cycle
  a_idle_after_done : assert property (@(posedge clk) disable iff (!rst_n_i)
    done_o |=> !busy_o);

endmodule

`default_nettype wire

/* design/ex_alu.sv */
// ALU of the execute stage with shared adder, logic unit, shifter and comparator
`default_nettype none
`timescale 1ns/1ps

module ex_alu (
  // Sampling clock for the operator check
  input  logic                    clk,
  input  ex_pkg::alu_op_e         operator_i,
  input  logic [ex_pkg::XLEN-1:0] operand_a_i,
  input  logic [ex_pkg::XLEN-1:0] operand_b_i,
  input  logic [4:0]              shifter_amt_i,
  output logic [ex_pkg::XLEN-1:0] adder_result_o,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    comparison_result_o
);

  import ex_pkg::*;

  // Adder
  logic                   adder_sub;
  logic [XLEN-1:0]        adder_op_b;
  logic [XLEN:0]          adder_full;

  // Comparator
  logic                   is_equal;
  logic                   is_less_s;
  logic                   is_less_u;

  // Shifter
  logic                   shift_left;
  logic                   shift_arith;
  logic [XLEN-1:0]        shift_op_a;
  logic [XLEN:0]          shift_ext;
  logic signed [XLEN:0]   shift_full;
  logic [XLEN-1:0]        shift_right;
  logic [XLEN-1:0]        shift_result;

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////

  // Subtract for SUB and for every compare
  always_comb begin
    case (operator_i)
      ALU_SUB, ALU_SLT, ALU_SLTU,
      ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU: adder_sub = 1'b1;
      default:                                          adder_sub = 1'b0;
    endcase
  end

  // Two's complement of b via inversion plus carry in
  assign adder_op_b = adder_sub ? ~operand_b_i : operand_b_i;
  assign adder_full = {1'b0, operand_a_i} + {1'b0, adder_op_b} + {{XLEN{1'b0}}, adder_sub};

  assign adder_result_o = adder_full[XLEN-1:0];

  ////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////

  // Difference is zero on equal operands
  assign is_equal  = (adder_result_o == '0);
  // No carry out of a - b means a borrow, so a < b unsigned
  assign is_less_u = ~adder_full[XLEN];
  // Signs differ: a is less when a is negative
  // Signs equal: no overflow, sign of the difference decides
  assign is_less_s = (operand_a_i[XLEN-1] ^ operand_b_i[XLEN-1]) ? operand_a_i[XLEN-1]
                                                                 : adder_result_o[XLEN-1];

  always_comb begin
    case (operator_i)
      ALU_EQ:            comparison_result_o = is_equal;
      ALU_NE:            comparison_result_o = ~is_equal;
      ALU_LT, ALU_SLT:   comparison_result_o = is_less_s;
      ALU_GE:            comparison_result_o = ~is_less_s;
      ALU_LTU, ALU_SLTU: comparison_result_o = is_less_u;
      ALU_GEU:           comparison_result_o = ~is_less_u;
      default:           comparison_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);

  // Left shift runs on the bit-reversed operand through the right shifter
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      shift_op_a[i] = shift_left ? operand_a_i[XLEN-1-i] : operand_a_i[i];
    end
  end

  // Extra top bit carries the sign fill for SRA only
  assign shift_ext   = {shift_arith & operand_a_i[XLEN-1], shift_op_a};
  assign shift_full  = $signed(shift_ext) >>> shifter_amt_i;
  assign shift_right = shift_full[XLEN-1:0];

  // Undo the reversal for left shifts
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      shift_result[i] = shift_left ? shift_right[XLEN-1-i] : shift_right[i];
    end
  end

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB:          result_o = adder_result_o;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      ALU_SLT, ALU_SLTU:         result_o = {{(XLEN-1){1'b0}}, comparison_result_o};
      // Branch compares write nothing back
      default:                   result_o = '0;
    endcase
  end

  // Operator from the ID/EX register must be a defined operation
  a_legal_operator : assert property (@(posedge clk)
    operator_i inside {ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
                       ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
                       ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU});

endmodule

`default_nettype wire

/* design/ex_pkg.sv */
// Execute stage package with data width, ALU operation codes and multiplier radix limits
`default_nettype none

package ex_pkg;

  // Datapath word width
  localparam int unsigned XLEN = 32;

  // Width of the operation code from decode
  localparam int unsigned ALU_OP_WIDTH = 5;

  // Bits of operand b retired per multiplier step
  localparam int unsigned MULT_RADIX_LOG2_MIN = 1;
  localparam int unsigned MULT_RADIX_LOG2_MAX = 4;

  ////////////////////////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////////////////////////

  // Bit 4 marks the branch compares
  // Bits 3:2 group the remaining units
  typedef enum logic [ALU_OP_WIDTH-1:0] {
    // Adder
    ALU_ADD  = 5'b00000,
    ALU_SUB  = 5'b00001,
    // Logic unit
    ALU_XOR  = 5'b00100,
    ALU_OR   = 5'b00101,
    ALU_AND  = 5'b00110,
    // Shifter
    ALU_SLL  = 5'b01000,
    ALU_SRL  = 5'b01001,
    ALU_SRA  = 5'b01010,
    // Set less than, result written back
    ALU_SLT  = 5'b01100,
    ALU_SLTU = 5'b01101,
    // Branch compares, result goes to the branch decision only
    ALU_EQ   = 5'b10000,
    ALU_NE   = 5'b10001,
    ALU_LT   = 5'b10010,
    ALU_GE   = 5'b10011,
    ALU_LTU  = 5'b10100,
    ALU_GEU  = 5'b10101
  } alu_op_e;

endpackage

`default_nettype wire
